/* fd_params.svh */
`ifndef FD_PARAMS_SVH
`define FD_PARAMS_SVH

// ------------------------------
// stream format
// ------------------------------
`define FD_DATA_W       32
`define FD_KEEP_W       4

// address words plus the tag word
`define FD_HDR_WORDS    4

// ------------------------------
// egress ports
// ------------------------------
`define FD_PORT_NUM     12
`define FD_LEVEL_W      32

// label of port 0, the rest follow in order
`define FD_LABEL_BASE   1

// congestion marking
`define FD_ALERT_LEVEL  3000
`define FD_ECN_MARK     1

`endif

/* fd_pkg.sv */
`default_nettype none
`include "fd_params.svh"

package fd_pkg;

    // one beat of the word stream
    typedef struct packed {
        logic [`FD_DATA_W-1:0] data;
        logic [`FD_KEEP_W-1:0] keep;
        logic                  last;
    } axis_word_t;

    // tag word fields, msb first
    typedef struct packed {
        logic [7:0]  label;
        logic [7:0]  ecn;
        logic [15:0] length_type;
    } hdr_tag_t;

    typedef union packed {
        logic [`FD_DATA_W-1:0] raw;
        hdr_tag_t              f;
    } hdr_tag_u;

    // captured header, ecn already resolved against the fifo level
    typedef struct packed {
        logic [`FD_DATA_W-1:0] addr_w0;
        logic [`FD_DATA_W-1:0] addr_w1;
        logic [`FD_DATA_W-1:0] addr_w2;
        hdr_tag_u              tag;
    } hdr_info_t;

    // fill level per egress fifo
    typedef logic [`FD_PORT_NUM-1:0][`FD_LEVEL_W-1:0] fifo_level_arr_t;

endpackage

`default_nettype wire

/* header_parser.sv */
`default_nettype none
`include "fd_params.svh"

module header_parser
    import fd_pkg::*;
(
    input  wire                         glb_clk,
    input  wire                         glb_areset_n,
    input  wire axis_word_t             s_word,
    input  wire                         s_valid,
    output logic                        s_ready,
    input  wire fifo_level_arr_t        fifo_levels,
    input  wire                         frame_done,
    output hdr_info_t                   hdr,
    output logic                        hdr_strobe,
    output logic                        pay_start,
    output logic [`FD_PORT_NUM-1:0]     bus_sel
);

    localparam int CNT_W = $clog2(`FD_HDR_WORDS + 2);
    // count stops once word 4 is past
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`FD_HDR_WORDS + 1);

    logic                       accept;
    logic [CNT_W-1:0]           word_cnt;
    logic                       draining;
    hdr_tag_u                   tag_in;
    hdr_tag_u                   tag_res;
    logic [`FD_PORT_NUM-1:0]    sel_next;
    logic                       congested;

    assign accept = s_valid && s_ready;

    // fires while word 3 is taken, so word 0 can leave on the next cycle
    assign hdr_strobe = accept && (word_cnt == CNT_W'(`FD_HDR_WORDS - 1));
    assign pay_start  = accept && (word_cnt == CNT_W'(`FD_HDR_WORDS));

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            word_cnt <= '0;
        end else if (accept) begin
            if (s_word.last) begin
                word_cnt <= '0;
            end else if (word_cnt != CNT_MAX) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // route decode and ecn marking
    // ------------------------------
    always_comb begin
        tag_in.raw = s_word.data;
        sel_next   = '0;
        congested  = 1'b0;
        for (int p = 0; p < `FD_PORT_NUM; p++) begin
            if (tag_in.f.label == 8'(`FD_LABEL_BASE + p)) begin
                sel_next[p] = 1'b1;
                congested   = fifo_levels[p] > `FD_LEVEL_W'(`FD_ALERT_LEVEL);
            end
        end
        tag_res = tag_in;
        if (congested) begin
            tag_res.f.ecn = 8'(`FD_ECN_MARK);
        end
    end

    // header words
    always_ff @(posedge glb_clk) begin
        if (accept) begin
            case (word_cnt)
                CNT_W'(0): hdr.addr_w0 <= s_word.data;
                CNT_W'(1): hdr.addr_w1 <= s_word.data;
                CNT_W'(2): hdr.addr_w2 <= s_word.data;
                CNT_W'(3): hdr.tag     <= tag_res;
                default: begin
                end
            endcase
        end
    end

    // route held until the output frame is done
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            bus_sel <= '0;
        end else if (hdr_strobe) begin
            bus_sel <= sel_next;
        end else if (frame_done) begin
            bus_sel <= '0;
        end
    end

    // ------------------------------
    // input ready
    // ------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            s_ready  <= 1'b0;
            draining <= 1'b0;
        end else if (accept && s_word.last) begin
            s_ready  <= 1'b0;
            draining <= 1'b1;
        end else if (frame_done) begin
            s_ready  <= 1'b1;
            draining <= 1'b0;
        end else if (!draining) begin
            s_ready  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* payload_aligner.sv */
`default_nettype none
`include "fd_params.svh"

module payload_aligner
    import fd_pkg::*;
(
    input  wire                 glb_clk,
    input  wire                 glb_areset_n,
    input  wire axis_word_t     s_word,
    input  wire                 s_valid,
    input  wire                 pay_start,
    output logic [7:0]          l0_byte,
    output axis_word_t          pay_word,
    output logic                pay_valid
);

    localparam int HELD_W = `FD_DATA_W - 8;

    logic                       active;
    logic                       tail_pending;
    logic                       take;
    logic                       ends_here;
    logic [HELD_W-1:0]          held;
    logic [`FD_KEEP_W-1:0]      tail_keep;

    // payload word after word 4
    assign take = active && s_valid;

    // one byte in the last word, no tail word needed
    assign ends_here = (s_word.keep >> 1) == '0;

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            active       <= 1'b0;
            tail_pending <= 1'b0;
            pay_valid    <= 1'b0;
        end else begin
            pay_valid    <= take || tail_pending;
            tail_pending <= take && s_word.last && !ends_here;
            if (pay_start) begin
                active <= 1'b1;
            end else if (take && s_word.last) begin
                active <= 1'b0;
            end
        end
    end

    // ------------------------------
    // byte realignment
    // ------------------------------
    always_ff @(posedge glb_clk) begin
        if (pay_start) begin
            l0_byte <= s_word.data[7:0];
            held    <= s_word.data[`FD_DATA_W-1:8];
        end else if (take) begin
            pay_word.data <= {s_word.data[7:0], held};
            pay_word.keep <= '1;
            pay_word.last <= s_word.last && ends_here;
            held          <= s_word.data[`FD_DATA_W-1:8];
            tail_keep     <= s_word.keep >> 1;
        end else if (tail_pending) begin
            // leftover upper bytes of the last input word
            pay_word.data <= {8'h00, held};
            pay_word.keep <= tail_keep;
            pay_word.last <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* frame_emitter.sv */
`default_nettype none
`include "fd_params.svh"

module frame_emitter
    import fd_pkg::*;
(
    input  wire                 glb_clk,
    input  wire                 glb_areset_n,
    input  wire hdr_info_t      hdr,
    input  wire                 hdr_strobe,
    input  wire [7:0]           l0_byte,
    input  wire axis_word_t     pay_word,
    input  wire                 pay_valid,
    output axis_word_t          m_word,
    output logic                m_valid,
    output logic                frame_done
);

    localparam int IDX_W = $clog2(`FD_HDR_WORDS);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`FD_HDR_WORDS - 1);

    logic [IDX_W-1:0]                           hdr_idx;
    hdr_tag_u                                   tag_out;
    logic [`FD_HDR_WORDS-1:0][`FD_DATA_W-1:0]   hdr_words;
    axis_word_t                                 dly_word;
    logic                                       dly_valid;
    axis_word_t                                 next_word;
    logic                                       next_valid;

    // L0 takes the place of the label
    always_comb begin
        tag_out.f.label       = l0_byte;
        tag_out.f.ecn         = hdr.tag.f.ecn;
        tag_out.f.length_type = hdr.tag.f.length_type;
    end

    assign hdr_words = {tag_out.raw, hdr.addr_w2, hdr.addr_w1, hdr.addr_w0};

    // ------------------------------
    // header sequencer
    // ------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            hdr_idx <= '0;
        end else if (hdr_strobe) begin
            hdr_idx <= IDX_W'(1);
        end else if (hdr_idx == IDX_LAST) begin
            hdr_idx <= '0;
        end else if (hdr_idx != '0) begin
            hdr_idx <= hdr_idx + 1'b1;
        end
    end

    // header words first, payload slots in right behind
    always_comb begin
        next_word  = dly_word;
        next_valid = dly_valid;
        if (hdr_strobe || hdr_idx != '0) begin
            next_word.data = hdr_words[hdr_idx];
            next_word.keep = '1;
            next_word.last = 1'b0;
            next_valid     = 1'b1;
        end
    end

    // ------------------------------
    // payload delay and output
    // ------------------------------
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            dly_valid  <= 1'b0;
            m_valid    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            dly_valid  <= pay_valid;
            m_valid    <= next_valid;
            frame_done <= m_valid && m_word.last;
        end
    end

    always_ff @(posedge glb_clk) begin
        dly_word <= pay_word;
        m_word   <= next_word;
    end

endmodule

`default_nettype wire

/* frame_decoder_top.sv */
`default_nettype none
`include "fd_params.svh"

module frame_decoder_top
    import fd_pkg::*;
(
    input  wire                         glb_clk,
    input  wire                         glb_areset_n,
    input  wire axis_word_t             s_word,
    input  wire                         s_valid,
    output logic                        s_ready,
    input  wire fifo_level_arr_t        fifo_levels,
    output axis_word_t                  m_word,
    output logic                        m_valid,
    output logic [`FD_PORT_NUM-1:0]     bus_sel
);

    hdr_info_t      hdr;
    logic           hdr_strobe;
    logic           pay_start;
    logic [7:0]     l0_byte;
    axis_word_t     pay_word;
    logic           pay_valid;
    logic           frame_done;

    header_parser i_header_parser (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_word       (s_word),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .fifo_levels  (fifo_levels),
        .frame_done   (frame_done),
        .hdr          (hdr),
        .hdr_strobe   (hdr_strobe),
        .pay_start    (pay_start),
        .bus_sel      (bus_sel)
    );

    payload_aligner i_payload_aligner (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_word       (s_word),
        .s_valid      (s_valid),
        .pay_start    (pay_start),
        .l0_byte      (l0_byte),
        .pay_word     (pay_word),
        .pay_valid    (pay_valid)
    );

    frame_emitter i_frame_emitter (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .hdr          (hdr),
        .hdr_strobe   (hdr_strobe),
        .l0_byte      (l0_byte),
        .pay_word     (pay_word),
        .pay_valid    (pay_valid),
        .m_word       (m_word),
        .m_valid      (m_valid),
        .frame_done   (frame_done)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none
`include "fd_params.svh"

module tb_checker
    import fd_pkg::*;
(
    input  wire                         glb_clk,
    input  wire                         glb_areset_n,
    input  wire axis_word_t             s_word,
    input  wire                         s_valid,
    input  wire                         s_ready,
    input  wire fifo_level_arr_t        fifo_levels,
    input  wire axis_word_t             m_word,
    input  wire                         m_valid,
    input  wire [`FD_PORT_NUM-1:0]      bus_sel,
    input  wire [8*16-1:0]              test_name,
    output int                          check_count,
    output int                          error_count,
    output int                          frame_count
);
    timeunit 1ns;
    timeprecision 1ns;

    int                         cyc;
    int                         t0;
    int                         out_idx;
    int                         hold;
    bit                         in_done;
    bit                         busy;
    bit [`FD_PORT_NUM-1:0]      sel_exp;
    logic [7:0]                 ecn_exp;
    logic [31:0]                in_q[$];
    logic [7:0]                 pay_q[$];

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("CHECK FAILED %0s %0s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic bit [`FD_PORT_NUM-1:0] decode_route(input logic [7:0] lbl);
        bit [`FD_PORT_NUM-1:0] sel;
        sel = '0;
        if (lbl >= 1 && lbl <= `FD_PORT_NUM) begin
            sel[lbl - 1] = 1'b1;
        end
        return sel;
    endfunction

    // ecn as the decoder should send it on, level taken with the tag word
    function automatic logic [7:0] resolve_ecn(input logic [31:0] tag);
        logic [7:0] lbl;
        lbl = tag[31:24];
        if (lbl >= 1 && lbl <= `FD_PORT_NUM) begin
            if (fifo_levels[lbl - 1] > 32'd3000) begin
                return 8'd1;
            end
        end
        return tag[23:16];
    endfunction

    task automatic check_output();
        int          j;
        int          nb;
        logic [31:0] exp_data;
        logic [31:0] mask;
        logic        exp_last;
        exp_data = '0;
        mask     = '0;
        nb       = 4;
        exp_last = 1'b0;
        if (out_idx < 3) begin
            exp_data = in_q[out_idx];
        end else if (out_idx == 3) begin
            exp_data = {in_q[4][7:0], ecn_exp, in_q[3][15:0]};
        end else begin
            // payload bytes after L0, four per word
            j  = 4 * (out_idx - 4);
            nb = pay_q.size() - j;
            exp_last = in_done && nb <= 4;
            nb = (nb > 4) ? 4 : ((nb < 0) ? 0 : nb);
            for (int b = 0; b < nb; b++) begin
                exp_data[8*b +: 8] = pay_q[j + b];
            end
        end
        for (int b = 0; b < nb; b++) begin
            mask[8*b +: 8] = 8'hff;
        end
        compare($sformatf("word %0d data", out_idx), exp_data, m_word.data & mask);
        compare($sformatf("word %0d keep", out_idx), 32'((1 << nb) - 1), 32'(m_word.keep));
        compare($sformatf("word %0d last", out_idx), 32'(exp_last), 32'(m_word.last));
        compare($sformatf("word %0d latency", out_idx), 32'd4, 32'(cyc - t0 - out_idx));
    endtask

    always @(posedge glb_clk) begin
        if (glb_areset_n) begin
            cyc++;
            // route and ready are released two cycles after the output last
            if (hold > 0) begin
                hold--;
                if (hold == 0) begin
                    sel_exp = '0;
                    busy    = 1'b0;
                    compare("s_ready after output last", 32'd1, 32'(s_ready));
                end
            end
            compare("bus_sel", 32'(sel_exp), 32'(bus_sel));
            if (busy) begin
                compare("s_ready after input last", 32'd0, 32'(s_ready));
            end

            if (s_valid && s_ready) begin
                if (in_q.size() == 0) begin
                    t0 = cyc;
                end
                in_q.push_back(s_word.data);
                if (in_q.size() == 4) begin
                    sel_exp = decode_route(s_word.data[31:24]);
                    ecn_exp = resolve_ecn(s_word.data);
                end else if (in_q.size() >= 5) begin
                    for (int b = (in_q.size() == 5) ? 1 : 0; b < 4; b++) begin
                        if (s_word.keep[b]) begin
                            pay_q.push_back(s_word.data[8*b +: 8]);
                        end
                    end
                end
                if (s_word.last) begin
                    in_done = 1'b1;
                    busy    = 1'b1;
                end
            end

            if (m_valid) begin
                if (in_q.size() == 0) begin
                    error_count++;
                    $display("m_valid is high while no frame is in flight");
                end else begin
                    check_output();
                    out_idx++;
                    if (m_word.last) begin
                        frame_count++;
                        hold    = 2;
                        out_idx = 0;
                        in_done = 1'b0;
                        in_q.delete();
                        pay_q.delete();
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_frame_decoder.sv */
`default_nettype none
`include "fd_params.svh"

module tb_frame_decoder
    import fd_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PERIOD     = 40;
    localparam int NUM_FRAMES = 8;
    // idle plus drain cycles per frame
    localparam int GAP_CYCLES = 8;

    typedef struct packed {
        logic [8*16-1:0] name;
        logic [7:0]      label;
        logic [7:0]      ecn;
        logic [15:0]     length_type;
        logic [7:0]      pay_bytes;
        logic [31:0]     level;
    } frame_cfg_t;

    logic                       glb_clk;
    logic                       glb_areset_n;
    axis_word_t                 s_word;
    logic                       s_valid;
    logic                       s_ready;
    fifo_level_arr_t            fifo_levels;
    axis_word_t                 m_word;
    logic                       m_valid;
    logic [`FD_PORT_NUM-1:0]    bus_sel;
    logic [8*16-1:0]            test_name;
    int                         check_count;
    int                         error_count;
    int                         frame_count;
    int                         tb_errors;
    int                         seed;
    bit                         wd_armed;
    longint                     wd_limit;
    frame_cfg_t                 frames [NUM_FRAMES];

    frame_decoder_top i_dut (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_word       (s_word),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .fifo_levels  (fifo_levels),
        .m_word       (m_word),
        .m_valid      (m_valid),
        .bus_sel      (bus_sel)
    );

    tb_checker i_checker (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_word       (s_word),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .fifo_levels  (fifo_levels),
        .m_word       (m_word),
        .m_valid      (m_valid),
        .bus_sel      (bus_sel),
        .test_name    (test_name),
        .check_count  (check_count),
        .error_count  (error_count),
        .frame_count  (frame_count)
    );

    initial begin
        glb_clk = 1'b0;
        forever #(PERIOD / 2) glb_clk = ~glb_clk;
    end

    task automatic send_frame(input frame_cfg_t cfg);
        int n_words;
        int left;
        int nb;
        n_words = 4 + (cfg.pay_bytes + 3) / 4;
        left    = cfg.pay_bytes;
        @(negedge glb_clk);
        while (!s_ready) begin
            @(negedge glb_clk);
        end
        test_name = cfg.name;
        // other ports get the opposite side of the alert level
        for (int p = 0; p < `FD_PORT_NUM; p++) begin
            if (cfg.label >= 1 && cfg.label <= `FD_PORT_NUM && cfg.label != p + 1) begin
                fifo_levels[p] = (cfg.level > 32'd3000) ? 32'd0 : 32'd4000;
            end else begin
                fifo_levels[p] = cfg.level;
            end
        end
        for (int i = 0; i < n_words; i++) begin
            s_valid     = 1'b1;
            s_word.data = (i == 3) ? {cfg.label, cfg.ecn, cfg.length_type} : $random(seed);
            s_word.keep = 4'hf;
            if (i >= 4) begin
                nb   = (left < 4) ? left : 4;
                left = left - nb;
                s_word.keep = 4'((1 << nb) - 1);
                for (int b = nb; b < 4; b++) begin
                    s_word.data[8*b +: 8] = 8'h00;
                end
            end
            s_word.last = (i == n_words - 1);
            @(negedge glb_clk);
        end
        s_valid = 1'b0;
        s_word  = '0;
        repeat (2) @(negedge glb_clk);
    endtask

    initial begin
        wait (wd_armed);
        #(wd_limit);
        $display("timeout: the run did not finish within %0d ns", wd_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int total_words;
        seed         = 32'h126356a0;
        glb_areset_n = 1'b0;
        s_word       = '0;
        s_valid      = 1'b0;
        fifo_levels  = '0;
        test_name    = "reset";
        tb_errors    = 0;

        // name, label, ecn, length/type, bytes from word 4 on, selected level
        frames[0] = '{"lbl1_congested", 8'd1, 8'h00, 16'h0800, 8'd8, 32'd3001};
        frames[1] = '{"lbl12_at_alert", 8'd12, 8'h02, 16'h86dd, 8'd9, 32'd3000};
        frames[2] = '{"lbl5_quiet", 8'd5, 8'h03, 16'h0806, 8'd10, 32'd10};
        frames[3] = '{"lbl0_unknown", 8'd0, 8'h02, 16'h0800, 8'd11, 32'd9999};
        frames[4] = '{"lblfe_unknown", 8'hfe, 8'h40, 16'h8100, 8'd17, 32'd5000};
        frames[5] = '{"lbl7_long", 8'd7, 8'h00, 16'h0600, 8'd23, 32'hffff_0000};
        frames[6] = '{"lbl3_short", 8'd3, 8'h11, 16'h0800, 8'd5, 32'd3000};
        frames[7] = '{"lbl9_two_bytes", 8'd9, 8'h00, 16'h05dc, 8'd6, 32'd3500};

        total_words = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            total_words += 4 + (frames[f].pay_bytes + 3) / 4;
        end
        wd_limit = longint'(total_words + NUM_FRAMES * GAP_CYCLES + 4) * 2 * PERIOD;
        wd_armed = 1'b1;

        repeat (2) @(posedge glb_clk);
        @(negedge glb_clk);
        glb_areset_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(frames[f]);
        end

        // last frame drains once ready comes back
        while (!s_ready) begin
            @(negedge glb_clk);
        end
        repeat (2) @(negedge glb_clk);

        if (frame_count != NUM_FRAMES) begin
            tb_errors++;
            $display("only %0d of %0d frames came out of the DUT", frame_count, NUM_FRAMES);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
fd_pkg.sv
header_parser.sv
payload_aligner.sv
frame_emitter.sv
frame_decoder_top.sv
tb_checker.sv
tb_frame_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_frame_decoder -f tb.f -o sim_frame_decoder

sim_out=$(./obj_dir/sim_frame_decoder)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
